/* eeprom_controller.sv */
`timescale 1ns/10ps

module eeprom_controller #(
    parameter eeprom_pkg::dev_code_t DEVICE_CODE = eeprom_pkg::DEFAULT_DEVICE_CODE
) (
    input  logic                   sda,
    input  logic                   rst_n,
    input  logic                   start_pulse,
    input  logic                   stop_pulse,
    input  logic                   bus_busy,
    input  logic                   rx_valid,
    input  eeprom_pkg::data_byte_t rx_byte,
    input  logic                   ack_done,
    input  logic                   master_ack,
    input  logic                   slot_end,
    input  eeprom_pkg::data_byte_t mem_rdata,
    output logic                   ack_enable,
    output logic                   tx_load,
    output eeprom_pkg::data_byte_t tx_byte,
    output logic                   tx_mode,
    output logic                   mem_we,
    output logic                   mem_re,
    output eeprom_pkg::mem_addr_t  mem_addr,
    output eeprom_pkg::data_byte_t mem_wdata
);

    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_control,
        st_address,
        st_write_data,
        st_read_fetch,
        st_read_send,
        st_ignore
    } ctrl_state_t;

    ctrl_state_t state;
    page_t       page_q;
    mem_addr_t   addr_q;
    logic        fetch_q;                       // Read data is on mem_rdata.

    assign mem_addr = addr_q;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= st_idle;
            addr_q     <= '0;
            ack_enable <= 1'b0;
            tx_load    <= 1'b0;
            tx_mode    <= 1'b0;
            mem_we     <= 1'b0;
            mem_re     <= 1'b0;
            fetch_q    <= 1'b0;
        end
        else
        begin
            tx_load <= 1'b0;
            mem_we  <= 1'b0;
            mem_re  <= 1'b0;
            fetch_q <= mem_re;
            if (mem_we || fetch_q)
                addr_q <= addr_q + 1'b1;        // Wraps over the whole array.

            if (stop_pulse)
            begin
                state      <= st_idle;
                ack_enable <= 1'b0;
                tx_mode    <= 1'b0;
            end
            else if (start_pulse)
            begin
                state      <= st_control;
                ack_enable <= 1'b0;
                tx_mode    <= 1'b0;
            end
            else if (bus_busy)
            begin
                case (state)
                    st_control:
                    begin
                        if (rx_valid && rx_byte[7:4] == DEVICE_CODE)
                        begin
                            ack_enable <= 1'b1;
                            state      <= rx_byte[0] ? st_read_fetch : st_address;
                        end
                        else if (rx_valid)
                            state <= st_ignore;     // Not addressed, no ack.
                    end
                    st_address:
                    begin
                        if (rx_valid)
                        begin
                            addr_q <= {page_q, rx_byte};
                            state  <= st_write_data;
                        end
                    end
                    st_write_data:
                    begin
                        if (rx_valid)
                            mem_we <= 1'b1;
                    end
                    st_read_fetch:
                    begin
                        // Fetch once the ack slot is over and SCL is low.
                        if (slot_end)
                        begin
                            ack_enable <= 1'b0;
                            tx_mode    <= 1'b1;
                            mem_re     <= 1'b1;
                        end
                        if (fetch_q)
                        begin
                            tx_load <= 1'b1;
                            state   <= st_read_send;
                        end
                    end
                    st_read_send:
                    begin
                        if (ack_done && master_ack)
                            state <= st_read_fetch;
                        else if (ack_done)
                        begin
                            tx_mode <= 1'b0;
                            state   <= st_ignore;
                        end
                    end
                    default:
                    begin
                        ack_enable <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (state == st_control && rx_valid)
            page_q <= rx_byte[3:1];
        if (state == st_write_data && rx_valid)
            mem_wdata <= rx_byte;
        if (fetch_q)
            tx_byte <= mem_rdata;
    end

endmodule

/* eeprom_mem.sv */
`timescale 1ns/10ps

module eeprom_mem (
    input  logic                   sda,
    input  logic                   mem_we,
    input  logic                   mem_re,
    input  eeprom_pkg::mem_addr_t  mem_addr,
    input  eeprom_pkg::data_byte_t mem_wdata,
    output eeprom_pkg::data_byte_t mem_rdata
);

    import eeprom_pkg::*;

    localparam int DEPTH = 2 ** $bits(mem_addr_t);

    data_byte_t mem_array [DEPTH];

    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem_array[i] = '0;                  // Blank part reads zero.
    end

    always_ff @(posedge sda)
    begin
        if (mem_we)
            mem_array[mem_addr] <= mem_wdata;
        if (mem_re)
            mem_rdata <= mem_array[mem_addr];
    end

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    // One bus byte or one memory word.
    typedef logic [7:0]  data_byte_t;

    // Page bits above the address byte.
    typedef logic [10:0] mem_addr_t;

    typedef logic [2:0]  page_t;       // Control byte bits 3 to 1.
    typedef logic [3:0]  dev_code_t;   // Control byte upper nibble.

    parameter int        DEFAULT_SYNC_STAGES = 2;
    parameter int        DEFAULT_FILTER_LEN  = 3;
    parameter dev_code_t DEFAULT_DEVICE_CODE = 4'b1010;

endpackage

/* eeprom_top.sv */
`timescale 1ns/10ps

module eeprom_top #(
    parameter int                    SYNC_STAGES = eeprom_pkg::DEFAULT_SYNC_STAGES,
    parameter int                    FILTER_LEN  = eeprom_pkg::DEFAULT_FILTER_LEN,
    parameter eeprom_pkg::dev_code_t DEVICE_CODE = eeprom_pkg::DEFAULT_DEVICE_CODE
) (
    input  logic sda,
    input  logic rst_n,
    input  logic i2c_scl,
    input  logic i2c_sda,
    output logic sda_drive_low
);

    import eeprom_pkg::*;

    logic       scl_level;
    logic       sda_level;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_pulse;
    logic       stop_pulse;
    logic       bus_busy;
    logic       rx_valid;
    data_byte_t rx_byte;
    logic       ack_done;
    logic       master_ack;
    logic       slot_end;
    logic       ack_enable;
    logic       tx_load;
    data_byte_t tx_byte;
    logic       tx_mode;
    logic       mem_we;
    logic       mem_re;
    mem_addr_t  mem_addr;
    data_byte_t mem_wdata;
    data_byte_t mem_rdata;

    i2c_line_filter #(
        .SYNC_STAGES (SYNC_STAGES),
        .FILTER_LEN  (FILTER_LEN)
    ) i_line_filter (
        .sda       (sda),
        .rst_n     (rst_n),
        .i2c_scl   (i2c_scl),
        .i2c_sda   (i2c_sda),
        .scl_level (scl_level),
        .sda_level (sda_level),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall)
    );

    i2c_condition_detect i_condition_detect (
        .sda         (sda),
        .rst_n       (rst_n),
        .scl_level   (scl_level),
        .sda_level   (sda_level),
        .start_pulse (start_pulse),
        .stop_pulse  (stop_pulse),
        .bus_busy    (bus_busy)
    );

    i2c_bit_engine i_bit_engine (
        .sda           (sda),
        .rst_n         (rst_n),
        .scl_level     (scl_level),
        .sda_level     (sda_level),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .start_pulse   (start_pulse),
        .ack_enable    (ack_enable),
        .tx_load       (tx_load),
        .tx_byte       (tx_byte),
        .tx_mode       (tx_mode),
        .rx_valid      (rx_valid),
        .rx_byte       (rx_byte),
        .ack_done      (ack_done),
        .master_ack    (master_ack),
        .slot_end      (slot_end),
        .sda_drive_low (sda_drive_low)
    );

    eeprom_controller #(
        .DEVICE_CODE (DEVICE_CODE)
    ) i_controller (
        .sda         (sda),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .stop_pulse  (stop_pulse),
        .bus_busy    (bus_busy),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .ack_done    (ack_done),
        .master_ack  (master_ack),
        .slot_end    (slot_end),
        .mem_rdata   (mem_rdata),
        .ack_enable  (ack_enable),
        .tx_load     (tx_load),
        .tx_byte     (tx_byte),
        .tx_mode     (tx_mode),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    eeprom_mem i_mem (
        .sda       (sda),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

/* filelist.f */
eeprom_pkg.sv
i2c_line_filter.sv
i2c_condition_detect.sv
i2c_bit_engine.sv
eeprom_controller.sv
eeprom_mem.sv
eeprom_top.sv
tb_eeprom.sv

/* i2c_bit_engine.sv */
`timescale 1ns/10ps

module i2c_bit_engine (
    input  logic                   sda,
    input  logic                   rst_n,
    input  logic                   scl_level,
    input  logic                   sda_level,
    input  logic                   scl_rise,
    input  logic                   scl_fall,
    input  logic                   start_pulse,
    input  logic                   ack_enable,
    input  logic                   tx_load,
    input  eeprom_pkg::data_byte_t tx_byte,
    input  logic                   tx_mode,
    output logic                   rx_valid,
    output eeprom_pkg::data_byte_t rx_byte,
    output logic                   ack_done,
    output logic                   master_ack,
    output logic                   slot_end,
    output logic                   sda_drive_low
);

    import eeprom_pkg::*;

    logic [3:0] bit_cnt;                        // Rising edges seen in this byte slot.
    data_byte_t rx_shift;
    data_byte_t tx_shift;
    logic       ack_q;
    logic       drive_q;
    logic       tx_shift_en;

    assign rx_byte       = rx_shift;
    assign master_ack    = ~ack_q;
    assign sda_drive_low = drive_q;
    assign slot_end      = scl_fall & (bit_cnt == 4'd9);

    // Falls after data bits 1 to 7 move the next transmit bit up.
    assign tx_shift_en = scl_fall & tx_mode & (bit_cnt != 4'd0) & (bit_cnt < 4'd8);

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt  <= 4'd0;
            rx_valid <= 1'b0;
            ack_done <= 1'b0;
            drive_q  <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            ack_done <= 1'b0;
            if (start_pulse)
            begin
                bit_cnt <= 4'd0;
                drive_q <= 1'b0;
            end
            else if (scl_rise)
            begin
                rx_valid <= (bit_cnt == 4'd7) & ~tx_mode;
                ack_done <= (bit_cnt == 4'd8) & tx_mode;
                if (bit_cnt != 4'd9)
                    bit_cnt <= bit_cnt + 1'b1;
            end
            else if (scl_fall)
            begin
                if (bit_cnt == 4'd9)
                begin
                    bit_cnt <= 4'd0;
                    drive_q <= 1'b0;
                end
                else if (bit_cnt == 4'd8)
                    drive_q <= ~tx_mode & ack_enable;   // Ack slot.
                else if (tx_shift_en)
                    drive_q <= ~tx_shift[6];
                else
                    drive_q <= 1'b0;
            end
            else if (tx_load && !scl_level)
                drive_q <= ~tx_byte[7];                 // MSB goes out while SCL is low.
        end
    end

    always_ff @(posedge sda)
    begin
        if (scl_rise && bit_cnt < 4'd8)
            rx_shift <= {rx_shift[6:0], sda_level};
        if (scl_rise && bit_cnt == 4'd8)
            ack_q <= sda_level;
        if (tx_load)
            tx_shift <= tx_byte;
        else if (tx_shift_en)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

endmodule

/* i2c_condition_detect.sv */
`timescale 1ns/10ps

module i2c_condition_detect (
    input  logic sda,
    input  logic rst_n,
    input  logic scl_level,
    input  logic sda_level,
    output logic start_pulse,
    output logic stop_pulse,
    output logic bus_busy
);

    logic sda_prev;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sda_prev    <= 1'b1;
            start_pulse <= 1'b0;
            stop_pulse  <= 1'b0;
            bus_busy    <= 1'b0;
        end
        else
        begin
            sda_prev    <= sda_level;
            // Data may only move while SCL is low, so an edge under SCL high is a condition.
            start_pulse <= scl_level & sda_prev & ~sda_level;
            stop_pulse  <= scl_level & ~sda_prev & sda_level;
            if (start_pulse)
                bus_busy <= 1'b1;
            else if (stop_pulse)
                bus_busy <= 1'b0;
        end
    end

endmodule

/* i2c_line_filter.sv */
`timescale 1ns/10ps

module i2c_line_filter #(
    parameter int SYNC_STAGES = eeprom_pkg::DEFAULT_SYNC_STAGES,
    parameter int FILTER_LEN  = eeprom_pkg::DEFAULT_FILTER_LEN
) (
    input  logic sda,
    input  logic rst_n,
    input  logic i2c_scl,
    input  logic i2c_sda,
    output logic scl_level,
    output logic sda_level,
    output logic scl_rise,
    output logic scl_fall
);

    localparam int CNT_W = $clog2(FILTER_LEN + 1);

    logic [1:0] line_in;
    logic [1:0] line_level;
    logic       scl_prev;

    assign line_in = {i2c_sda, i2c_scl};

    for (genvar i = 0; i < 2; i++)
    begin : g_line
        logic [SYNC_STAGES-1:0] sync_q;
        logic [CNT_W-1:0]       run_cnt;
        logic                   level_q;

        always_ff @(posedge sda or negedge rst_n)
        begin
            if (!rst_n)
            begin
                sync_q  <= '1;                  // Idle bus reads high.
                run_cnt <= '0;
                level_q <= 1'b1;
            end
            else
            begin
                sync_q <= {sync_q[SYNC_STAGES-2:0], line_in[i]};
                if (sync_q[SYNC_STAGES-1] == level_q)
                    run_cnt <= '0;
                else if (run_cnt == CNT_W'(FILTER_LEN - 1))
                begin
                    run_cnt <= '0;
                    level_q <= sync_q[SYNC_STAGES-1];
                end
                else
                    run_cnt <= run_cnt + 1'b1;
            end
        end

        assign line_level[i] = level_q;
    end

    assign scl_level = line_level[0];
    assign sda_level = line_level[1];

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
            scl_prev <= 1'b1;
        else
            scl_prev <= scl_level;
    end

    assign scl_rise = scl_level & ~scl_prev;
    assign scl_fall = ~scl_level & scl_prev;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f filelist.f --top-module tb_eeprom

status=0
./obj_dir/Vtb_eeprom > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_eeprom.sv */
`timescale 1ns/10ps

module tb_eeprom;

    import eeprom_pkg::*;

    localparam int HALF_PHASE   = 10;                   // Half of one SCL phase in clocks.
    localparam int LINE_TIMEOUT = 200;
    localparam int MEM_DEPTH    = 2 ** $bits(mem_addr_t);

    logic       sda = 1'b0;
    logic       rst_n;
    logic       i2c_scl;
    logic       master_low;
    logic       sda_drive_low;
    wire        i2c_sda;

    data_byte_t model_mem [MEM_DEPTH];
    data_byte_t burst [4];

    assign i2c_sda = ~(master_low | sda_drive_low);     // Pull-up unless someone pulls low.

    eeprom_top #(
        .SYNC_STAGES (DEFAULT_SYNC_STAGES),
        .FILTER_LEN  (DEFAULT_FILTER_LEN),
        .DEVICE_CODE (DEFAULT_DEVICE_CODE)
    ) i_eeprom_top (
        .sda           (sda),
        .rst_n         (rst_n),
        .i2c_scl       (i2c_scl),
        .i2c_sda       (i2c_sda),
        .sda_drive_low (sda_drive_low)
    );

    always #4 sda = ~sda;

    task automatic wait_clocks(input int count);
        repeat (count) @(posedge sda);
    endtask

    task automatic fail_with_message(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s expected %0h actual %0h", test_name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_line_high(input string what);
        int cycles;
        cycles = 0;
        while (i2c_sda !== 1'b1 && cycles < LINE_TIMEOUT)
        begin
            @(posedge sda);
            cycles++;
        end
        if (i2c_sda !== 1'b1)
            fail_with_message({"data line stayed low ", what});
    endtask

    task automatic expect_ack(input string test_name, input string what,
                              input logic got_ack, input logic want_ack);
        if (got_ack !== want_ack)
        begin
            if (want_ack)
                fail_with_message($sformatf("%s: no acknowledge for the %s", test_name, what));
            else
                fail_with_message($sformatf("%s: the %s was acknowledged unexpectedly",
                                            test_name, what));
        end
    endtask

    // One SCL clock; drive_bit high releases the line.
    task automatic clock_bit(input logic drive_bit, output logic line_bit);
        master_low <= ~drive_bit;
        wait_clocks(HALF_PHASE);
        i2c_scl <= 1'b1;
        wait_clocks(HALF_PHASE);
        line_bit = i2c_sda;                             // Mid-high sample.
        wait_clocks(HALF_PHASE);
        i2c_scl <= 1'b0;
        wait_clocks(HALF_PHASE);
    endtask

    task automatic send_start();
        master_low <= 1'b0;
        wait_clocks(HALF_PHASE);
        i2c_scl <= 1'b1;
        wait_line_high("before a start");
        wait_clocks(HALF_PHASE);
        master_low <= 1'b1;                             // Data falls under SCL high.
        wait_clocks(HALF_PHASE);
        i2c_scl <= 1'b0;
        wait_clocks(HALF_PHASE);
    endtask

    task automatic send_stop();
        master_low <= 1'b1;
        wait_clocks(HALF_PHASE);
        i2c_scl <= 1'b1;
        wait_clocks(HALF_PHASE);
        master_low <= 1'b0;                             // Data rises under SCL high.
        wait_line_high("after a stop");
        wait_clocks(2 * HALF_PHASE);
    endtask

    task automatic write_byte(input data_byte_t value, output logic ack);
        logic line_bit;
        for (int i = 7; i >= 0; i--)
            clock_bit(value[i], line_bit);
        clock_bit(1'b1, line_bit);
        ack = ~line_bit;
    endtask

    task automatic read_byte(input logic ack, output data_byte_t value);
        logic line_bit;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, line_bit);
            value[i] = line_bit;
        end
        clock_bit(~ack, line_bit);
    endtask

    function automatic data_byte_t control_byte(input mem_addr_t addr, input logic read);
        return {DEFAULT_DEVICE_CODE, addr[10:8], read};
    endfunction

    task automatic send_address(input string test_name, input mem_addr_t addr);
        logic ack;
        send_start();
        write_byte(control_byte(addr, 1'b0), ack);
        expect_ack(test_name, "write control byte", ack, 1'b1);
        write_byte(addr[7:0], ack);
        expect_ack(test_name, "address byte", ack, 1'b1);
    endtask

    task automatic write_burst(input string test_name, input mem_addr_t addr, input int count);
        logic ack;
        send_address(test_name, addr);
        for (int i = 0; i < count; i++)
        begin
            write_byte(burst[i], ack);
            expect_ack(test_name, "data byte", ack, 1'b1);
            model_mem[addr + mem_addr_t'(i)] = burst[i];
        end
        send_stop();
    endtask

    // Random read with a repeated start; the last byte gets a not-acknowledge.
    task automatic read_check(input string test_name, input mem_addr_t addr, input int count);
        logic       ack;
        data_byte_t value;
        send_address(test_name, addr);
        send_start();
        write_byte(control_byte(addr, 1'b1), ack);
        expect_ack(test_name, "read control byte", ack, 1'b1);
        for (int i = 0; i < count; i++)
        begin
            read_byte(i < count - 1, value);
            check_value(test_name, 32'(model_mem[addr + mem_addr_t'(i)]), 32'(value));
        end
        send_stop();
    endtask

    task automatic current_read_check(input string test_name, input mem_addr_t addr);
        logic       ack;
        data_byte_t value;
        send_start();
        write_byte(control_byte(addr, 1'b1), ack);
        expect_ack(test_name, "read control byte", ack, 1'b1);
        read_byte(1'b0, value);
        check_value(test_name, 32'(model_mem[addr]), 32'(value));
        send_stop();
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 50; i++)
        begin
            wait_clocks(1);
            check_value("test_reset_idle", 32'd1, 32'(i2c_sda));
            check_value("test_reset_idle", 32'd0, 32'(sda_drive_low));
        end
    endtask

    task automatic test_random_rw();
        mem_addr_t addr;
        addr     = mem_addr_t'($urandom);
        burst[0] = data_byte_t'($urandom);
        write_burst("test_random_rw", addr, 1);
        read_check("test_random_rw", addr, 1);
    endtask

    task automatic test_sequential();
        mem_addr_t addr;
        addr = mem_addr_t'($urandom);
        for (int i = 0; i < 4; i++)
            burst[i] = data_byte_t'($urandom);
        write_burst("test_sequential", addr, 4);
        read_check("test_sequential", addr, 4);
        for (int i = 0; i < 20; i++)
        begin
            wait_clocks(1);
            check_value("test_sequential", 32'd0, 32'(sda_drive_low));
            check_value("test_sequential", 32'd1, 32'(i2c_sda));
        end
    endtask

    task automatic test_pages();
        data_byte_t addr_byte;
        addr_byte = data_byte_t'($urandom);
        burst[0]  = data_byte_t'($urandom);
        write_burst("test_pages", {3'd0, addr_byte}, 1);
        burst[0]  = ~burst[0];                          // Page 7 gets a different byte.
        write_burst("test_pages", {3'd7, addr_byte}, 1);
        read_check("test_pages", {3'd0, addr_byte}, 1);
        read_check("test_pages", {3'd7, addr_byte}, 1);
    endtask

    task automatic test_wrong_device();
        mem_addr_t addr;
        logic      ack;
        addr = mem_addr_t'($urandom);
        send_start();
        write_byte({4'b1011, addr[10:8], 1'b0}, ack);
        expect_ack("test_wrong_device", "wrong device code", ack, 1'b0);
        write_byte(addr[7:0], ack);
        expect_ack("test_wrong_device", "ignored address byte", ack, 1'b0);
        write_byte(~model_mem[addr], ack);
        expect_ack("test_wrong_device", "ignored data byte", ack, 1'b0);
        send_stop();
        read_check("test_wrong_device", addr, 1);
    endtask

    task automatic test_abort_write();
        mem_addr_t  addr;
        data_byte_t value;
        logic       line_bit;
        addr     = mem_addr_t'($urandom);
        burst[0] = data_byte_t'($urandom);
        burst[1] = data_byte_t'($urandom);
        write_burst("test_abort_write", addr, 2);
        value = ~model_mem[addr];
        send_address("test_abort_write", addr);
        for (int i = 7; i >= 4; i--)
            clock_bit(value[i], line_bit);              // Half a byte, then cut off.
        send_stop();
        read_check("test_abort_write", addr, 1);
        current_read_check("test_abort_write", addr + 11'd1);
    endtask

    initial
    begin
        rst_n      <= 1'b0;
        i2c_scl    <= 1'b1;
        master_low <= 1'b0;
        void'($urandom(32'hb4a4_96a7));
        for (int i = 0; i < MEM_DEPTH; i++)
            model_mem[i] = '0;                          // Blank part reads zero.
        wait_clocks(5);
        rst_n <= 1'b1;
        wait_clocks(2);

        test_reset_idle();
        test_random_rw();
        test_sequential();
        test_pages();
        test_wrong_device();
        test_abort_write();

        $display("TEST OK");
        $finish;
    end

endmodule
